//--- src.f
+incdir+verif
hdl/csr_pkg.sv
hdl/csr_write_data.sv
hdl/csr_machine_regs.sv
hdl/csr_counters.sv
hdl/csr_irq_ctrl.sv
hdl/csr_read_mux.sv
hdl/csr_bank.sv
verif/tb_csr_bank.sv

//--- Makefile
# Verilator flow for the CSR bank testbench

TOP = tb_csr_bank

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_csr_tasks.svh
// Directed tests for the CSR bank testbench
// Each test drives the DUT and checks the response against the model

task automatic reset_values();
    logic [31:0] value;
    expect_csr("misa", MISA);
    expect_csr("mstatus", MSTATUS);
    expect_csr("mie", MIE);
    expect_csr("mtvec", MTVEC);
    expect_csr("mscratch", MSCRATCH);
    expect_csr("mepc", MEPC);
    expect_csr("mcause", MCAUSE);
    expect_csr("mtval", MTVAL);
    expect_csr("mvendorid", MVENDORID);
    read_csr(csr_addr_e'(12'h7C0), value);   // Not a CSR of this bank
    check_value("rdata_o unknown address", 32'h0, value);
    check_value("privilege_o", 32'(PRIV_MACHINE), 32'(privilege));
    check_value("interrupt_pending_o", 32'h0, 32'(interrupt_pending));
endtask

task automatic masked_operations();
    logic [31:0] value;
    masked_op("mstatus write", CSR_WRITE, MSTATUS, 32'hFFFFFFFF);
    masked_op("mstatus clear", CSR_CLEAR, MSTATUS, 32'h00001888);
    masked_op("mstatus set", CSR_SET, MSTATUS, 32'h00000008);
    masked_op("mtvec write", CSR_WRITE, MTVEC, 32'h80000103);
    masked_op("mtvec set", CSR_SET, MTVEC, 32'h000000F3);
    masked_op("mtvec clear", CSR_CLEAR, MTVEC, 32'h80000000);
    masked_op("mie write", CSR_WRITE, MIE, 32'hFFFFFFFF);
    masked_op("mie clear", CSR_CLEAR, MIE, 32'h00000008);
    masked_op("mie set", CSR_SET, MIE, 32'h0000000F);
    masked_op("mscratch write", CSR_WRITE, MSCRATCH, 32'h12345678);
    masked_op("mscratch set", CSR_SET, MSCRATCH, 32'hF0000000);
    masked_op("mscratch clear", CSR_CLEAR, MSCRATCH, 32'h00000078);
    check_value("mtvec_o", model[MTVEC], mtvec);

    drive_access(1'b0, 1'b1, 1'b1, CSR_WRITE, MSCRATCH, 32'h0BADF00D, value);
    expect_csr("mscratch after killed write", MSCRATCH);
    drive_access(1'b1, 1'b0, 1'b1, CSR_WRITE, MSCRATCH, 32'h0, value);
    check_value("rdata_o killed read", 32'h0, value);
endtask

task automatic counter_behavior();
    logic [31:0] first;
    logic [31:0] second;
    read_csr(MCYCLE, first);
    idle(7);
    read_csr(MCYCLE, second);
    check_value("mcycle delta", 32'd8, second - first);

    drive_access(1'b0, 1'b1, 1'b0, CSR_WRITE, MCYCLEH, 32'h000000A5, first);
    read_csr(CYCLEH, second);
    check_value("cycleh", 32'h000000A5, second);

    // Only the read cycle retires, the killed slots do not
    read_csr(MINSTRET, first);
    repeat (5) drive_access(1'b0, 1'b0, 1'b1, CSR_WRITE, MINSTRET, 32'h0, second);
    read_csr(INSTRET, second);
    check_value("instret delta", 32'd1, second - first);
endtask

task automatic model_trap_entry(input logic [31:0] cause, input logic [31:0] epc);
    logic [31:0] status;
    status = model[MSTATUS];
    status[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b11;   // Trap taken from machine mode
    status[MSTATUS_MPIE] = status[MSTATUS_MIE];
    status[MSTATUS_MIE]  = 1'b0;
    model[MSTATUS] = status;
    model[MCAUSE]  = cause;
    model[MEPC]    = epc;
endtask

task automatic machine_return();
    trap_req_t req;
    req = '0;
    req.machine_return = 1'b1;
    raise_trap(req);
    model[MSTATUS][MSTATUS_MIE] = model[MSTATUS][MSTATUS_MPIE];
    expect_csr("mstatus after mret", MSTATUS);
    check_value("privilege_o after mret", 32'(PRIV_MACHINE), 32'(privilege));
endtask

task automatic exception_entry_return();
    trap_req_t req;
    masked_op("mstatus set MIE", CSR_SET, MSTATUS, 32'h00000008);

    req = '0;
    req.raise_exception = 1'b1;
    req.exc_code        = ILLEGAL_INSTRUCTION;
    req.pc              = 32'h00001000;
    req.instruction     = 32'hDEADBEEF;
    raise_trap(req);
    model_trap_entry(32'd2, req.pc + 32'd4);
    model[MTVAL] = req.instruction;
    expect_csr("mcause illegal", MCAUSE);
    expect_csr("mtval illegal", MTVAL);
    expect_csr("mepc illegal", MEPC);
    expect_csr("mstatus illegal", MSTATUS);
    check_value("mepc_o", model[MEPC], mepc);
    machine_return();

    req.exc_code = BREAKPOINT;
    req.pc       = 32'h00002000;
    raise_trap(req);
    model_trap_entry(32'd3, req.pc);
    model[MTVAL] = req.pc;
    expect_csr("mcause breakpoint", MCAUSE);
    expect_csr("mtval breakpoint", MTVAL);
    expect_csr("mepc breakpoint", MEPC);
    expect_csr("mstatus breakpoint", MSTATUS);
    machine_return();
endtask

task automatic interrupt_entry();
    trap_req_t   req;
    logic [31:0] value;
    int          waited;
    masked_op("mie enable", CSR_WRITE, MIE, 32'h00000808);
    masked_op("mstatus set MIE", CSR_SET, MSTATUS, 32'h00000008);
    idle(1);
    irq    = 32'h00000808;   // Software and external lines
    waited = 0;
    while (!interrupt_pending && waited < 10) begin
        idle(1);
        waited++;
    end
    if (!interrupt_pending) begin
        error_count++;
        $display("interrupt_pending_o did not rise within 10 cycles of the IRQ lines");
    end
    read_csr(MIP, value);
    check_value("mip", 32'h00000808, value);

    req = '0;
    req.interrupt_ack = 1'b1;
    req.pc            = 32'h00003000;
    req.jump          = 1'b1;
    req.jump_target   = 32'h00004468;
    raise_trap(req);
    model_trap_entry(32'h8000000B, req.jump_target);
    idle(1);
    check_value("interrupt_pending_o after ack", 32'h0, 32'(interrupt_pending));
    irq = '0;
    expect_csr("mcause interrupt", MCAUSE);
    expect_csr("mepc interrupt", MEPC);
    expect_csr("mstatus interrupt", MSTATUS);
    check_value("mepc_o interrupt", model[MEPC], mepc);
endtask

task automatic random_readback();
    for (int i = 0; i < 12; i++) begin
        masked_op("mscratch random", CSR_WRITE, MSCRATCH, random_word());
        masked_op("mtval random", CSR_WRITE, MTVAL, random_word());
        masked_op("mtvec random", CSR_WRITE, MTVEC, random_word());
    end
endtask

//--- verif/tb_csr_bank.sv
// Testbench for the machine-mode CSR bank
// Directed tests checked against a register model kept by address
`timescale 1ns/1ps

module tb_csr_bank;

    import csr_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int TEST_CYCLES    = 400;             // Rough length of all tests
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    logic        clk;
    logic        reset;
    csr_access_t csr_access;
    trap_req_t   trap_req;
    logic [31:0] irq;
    logic [31:0] rdata;
    logic        interrupt_pending;
    priv_e       privilege;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    int          error_count;
    int          check_count;
    logic [31:0] lfsr_state;
    logic [31:0] model [0:4095];   // Expected CSR contents by address

    csr_bank #(
        .MISA_RESET (32'h40000100)
    ) csr_bank_i (
        .clk                 (clk),
        .reset               (reset),
        .csr_access_i        (csr_access),
        .trap_req_i          (trap_req),
        .irq_i               (irq),
        .rdata_o             (rdata),
        .interrupt_pending_o (interrupt_pending),
        .privilege_o         (privilege),
        .mtvec_o             (mtvec),
        .mepc_o              (mepc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] time %0d ns signal %s expected %08h actual %08h",
                     $time, name, expected, actual);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        for (int i = 0; i < 32; i++) begin
            word[i] = lfsr_step();
        end
        return word;
    endfunction

    function automatic logic [31:0] write_mask(input csr_addr_e addr);
        case (addr)
            MSTATUS:                 return 32'h007E19AA;
            MISA:                    return 32'h3C000000;
            MIE:                     return 32'h00000888;
            MTVEC, MEPC:             return 32'hFFFFFFFC;
            MSCRATCH, MCAUSE, MTVAL: return 32'hFFFFFFFF;
            MCYCLE, MCYCLEH:         return 32'hFFFFFFFF;
            MINSTRET, MINSTRETH:     return 32'hFFFFFFFF;
            default:                 return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] apply_op(input csr_op_e op, input logic [31:0] cur,
                                             input logic [31:0] data);
        case (op)
            CSR_SET:   return cur | data;
            CSR_CLEAR: return cur & ~data;
            default:   return data;
        endcase
    endfunction

    // One cycle of CSR access, read data sampled after the inputs settle
    task automatic drive_access(input logic rd, input logic wr, input logic kill,
                                input csr_op_e op, input csr_addr_e addr,
                                input logic [31:0] data, output logic [31:0] rd_data);
        @(negedge clk);
        trap_req   = '0;
        csr_access = '{read_en: rd, write_en: wr, op: op, addr: addr, data: data, kill: kill};
        #1 rd_data = rdata;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            csr_access = '0;
            trap_req   = '0;
        end
    endtask

    task automatic read_csr(input csr_addr_e addr, output logic [31:0] value);
        drive_access(1'b1, 1'b0, 1'b0, CSR_WRITE, addr, 32'h0, value);
    endtask

    task automatic expect_csr(input string name, input csr_addr_e addr);
        logic [31:0] value;
        read_csr(addr, value);
        check_value(name, model[addr], value);
    endtask

    task automatic masked_op(input string name, input csr_op_e op, input csr_addr_e addr,
                             input logic [31:0] data);
        logic [31:0] unused;
        drive_access(1'b0, 1'b1, 1'b0, op, addr, data, unused);
        model[addr] = apply_op(op, model[addr], data) & write_mask(addr);
        expect_csr(name, addr);
    endtask

    task automatic raise_trap(input trap_req_t req);
        @(negedge clk);
        csr_access = '0;
        trap_req   = req;
    endtask

    `include "tb_csr_tasks.svh"

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        csr_access  = '0;
        trap_req    = '0;
        irq         = '0;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 32'h8eccd1f9;
        for (int a = 0; a < 4096; a++) begin
            model[a] = '0;
        end
        model[MISA] = 32'h40000100;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_values();
        masked_operations();
        counter_behavior();
        exception_entry_return();
        interrupt_entry();
        random_readback();
        idle(2);

        $display("Run complete with %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock periods, tests did not finish",
                 TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- hdl/csr_bank.sv
// Machine-mode CSR bank top level
// Connects read mux, write data path, trap registers, counters and IRQ control
`timescale 1ns/1ps

module csr_bank #(
    parameter logic [31:0] MISA_RESET = 32'h40000100   // RV32I
) (
    input  logic                           clk,
    input  logic                           reset,
    input  csr_pkg::csr_access_t           csr_access_i,
    input  csr_pkg::trap_req_t             trap_req_i,
    input  logic [31:0]                    irq_i,
    output logic [31:0]                    rdata_o,
    output logic                           interrupt_pending_o,
    output csr_pkg::priv_e                 privilege_o,
    output logic [31:0]                    mtvec_o,
    output logic [31:0]                    mepc_o
);

    import csr_pkg::*;

    machine_state_t  state;
    counter_state_t  counters;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] current_val;   // Ungated value for set and clear
    logic [XLEN-1:0] wdata;
    irq_code_e       irq_code;

    csr_read_mux read_mux_i (
        .csr_access_i  (csr_access_i),
        .state_i       (state),
        .counters_i    (counters),
        .mip_i         (mip),
        .rdata_o       (rdata_o),
        .current_val_o (current_val)
    );

    csr_write_data write_data_i (
        .csr_access_i  (csr_access_i),
        .current_val_i (current_val),
        .wdata_o       (wdata)
    );

    csr_machine_regs #(
        .MISA_RESET (MISA_RESET)
    ) machine_regs_i (
        .clk          (clk),
        .reset        (reset),
        .csr_access_i (csr_access_i),
        .trap_req_i   (trap_req_i),
        .wdata_i      (wdata),
        .irq_code_i   (irq_code),
        .state_o      (state),
        .privilege_o  (privilege_o)
    );

    csr_counters counters_i (
        .clk          (clk),
        .reset        (reset),
        .csr_access_i (csr_access_i),
        .wdata_i      (wdata),
        .counters_o   (counters)
    );

    csr_irq_ctrl irq_ctrl_i (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .mie_i               (state.mie),
        .mstatus_mie_i       (state.mstatus[MSTATUS_MIE]),
        .interrupt_ack_i     (trap_req_i.interrupt_ack),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

    assign mtvec_o = state.mtvec;   // Trap vector for the fetch unit
    assign mepc_o  = state.mepc;

endmodule

//--- hdl/csr_read_mux.sv
// CSR read multiplexer
// Selects a register by address for reads and for set/clear operations
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_access_t           csr_access_i,
    input  csr_pkg::machine_state_t        state_i,
    input  csr_pkg::counter_state_t        counters_i,
    input  logic [31:0]                    mip_i,
    output logic [31:0]                    rdata_o,
    output logic [31:0]                    current_val_o
);

    import csr_pkg::*;

    logic [XLEN-1:0] selected;
    logic            read_ok;

    always_comb begin
        case (csr_access_i.addr)
            // ID registers are not implemented
            MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR: begin
                selected = '0;
            end
            MSTATUS:   selected = state_i.mstatus;
            MISA:      selected = state_i.misa;
            MIE:       selected = state_i.mie;
            MTVEC:     selected = state_i.mtvec;
            MSCRATCH:  selected = state_i.mscratch;
            MEPC:      selected = state_i.mepc;
            MCAUSE:    selected = state_i.mcause;
            MTVAL:     selected = state_i.mtval;
            MIP:       selected = mip_i;
            MCYCLE,
            CYCLE:     selected = counters_i.mcycle[31:0];
            MCYCLEH,
            CYCLEH:    selected = counters_i.mcycle[63:32];
            MINSTRET,
            INSTRET:   selected = counters_i.minstret[31:0];
            MINSTRETH,
            INSTRETH:  selected = counters_i.minstret[63:32];
            default:   selected = '0;   // Unknown address
        endcase
    end

    assign read_ok = csr_access_i.read_en && !csr_access_i.kill;

    assign rdata_o       = read_ok ? selected : '0;
    assign current_val_o = selected;   // Not gated, feeds set and clear

endmodule

//--- hdl/csr_irq_ctrl.sv
// Interrupt controller for the CSR bank
// Samples IRQ lines into mip and registers the pending flag and cause
`timescale 1ns/1ps

module csr_irq_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    irq_i,
    input  logic [31:0]                    mie_i,
    input  logic                           mstatus_mie_i,
    input  logic                           interrupt_ack_i,
    output logic [31:0]                    mip_o,
    output logic                           interrupt_pending_o,
    output csr_pkg::irq_code_e             irq_code_o
);

    import csr_pkg::*;

    logic [31:0] mip;
    logic [31:0] enabled;
    logic        take;

    assign enabled = mie_i & mip;
    assign take    = mstatus_mie_i && (enabled != '0) && !interrupt_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip <= '0;
        end
        else begin
            mip <= irq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt_pending_o <= 1'b0;
        end
        else begin
            interrupt_pending_o <= take;   // Drops the clock after an acknowledge
        end
    end

    // Cause held until the next pending cycle, external first
    always_ff @(posedge clk) begin
        if (take) begin
            if (enabled[M_EXT_INT]) begin
                irq_code_o <= M_EXT_INT;
            end
            else if (enabled[M_SW_INT]) begin
                irq_code_o <= M_SW_INT;
            end
            else if (enabled[M_TIM_INT]) begin
                irq_code_o <= M_TIM_INT;
            end
        end
    end

    assign mip_o = mip;

endmodule

//--- hdl/csr_counters.sv
// Cycle and retired-instruction counters
// 64-bit machine counters, writable by halves from software
`timescale 1ns/1ps

module csr_counters (
    input  logic                           clk,
    input  logic                           reset,
    input  csr_pkg::csr_access_t           csr_access_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i,
    output csr_pkg::counter_state_t        counters_o
);

    import csr_pkg::*;

    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic        sw_write;

    assign sw_write = csr_access_i.write_en && !csr_access_i.kill;

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end
        else begin
            mcycle <= mcycle + 64'd1;
            if (!csr_access_i.kill) begin
                minstret <= minstret + 64'd1;   // Killed slots do not retire
            end

            // Later assignment wins over the increment for the written half
            if (sw_write) begin
                case (csr_access_i.addr)
                    MCYCLE:    mcycle[31:0]    <= wdata_i;
                    MCYCLEH:   mcycle[63:32]   <= wdata_i;
                    MINSTRET:  minstret[31:0]  <= wdata_i;
                    MINSTRETH: minstret[63:32] <= wdata_i;
                    default:   ;
                endcase
            end
        end
    end

    assign counters_o.mcycle   = mcycle;
    assign counters_o.minstret = minstret;

endmodule

//--- hdl/csr_machine_regs.sv
// Machine trap registers and current privilege level
// Handles trap entry, machine return and software CSR writes
`timescale 1ns/1ps

module csr_machine_regs #(
    parameter logic [31:0] MISA_RESET = 32'h40000100
) (
    input  logic                           clk,
    input  logic                           reset,
    input  csr_pkg::csr_access_t           csr_access_i,
    input  csr_pkg::trap_req_t             trap_req_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i,
    input  csr_pkg::irq_code_e             irq_code_i,
    output csr_pkg::machine_state_t        state_o,
    output csr_pkg::priv_e                 privilege_o
);

    import csr_pkg::*;

    machine_state_t regs;
    priv_e          privilege;
    logic           sw_write;
    logic           exc_at_pc;      // Return address is the faulting pc

    assign sw_write  = csr_access_i.write_en && !csr_access_i.kill;
    assign exc_at_pc = trap_req_i.exc_code inside {ECALL_FROM_MMODE, BREAKPOINT};

    always_ff @(posedge clk) begin
        if (reset) begin
            regs      <= '0;
            regs.misa <= MISA_RESET;
            privilege <= PRIV_MACHINE;
        end
        else if (trap_req_i.machine_return) begin
            regs.mstatus[MSTATUS_MIE] <= regs.mstatus[MSTATUS_MPIE];
            privilege <= priv_e'(regs.mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
        end
        else if (trap_req_i.raise_exception) begin
            regs.mcause <= {1'b0, 26'b0, trap_req_i.exc_code};
            regs.mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= privilege;
            regs.mstatus[MSTATUS_MPIE] <= regs.mstatus[MSTATUS_MIE];
            regs.mstatus[MSTATUS_MIE]  <= 1'b0;
            privilege <= PRIV_MACHINE;

            if (exc_at_pc) begin
                regs.mepc <= trap_req_i.pc;
            end
            else begin
                regs.mepc <= trap_req_i.pc + 32'd4;
            end

            // Faulting word for illegal instructions, pc for the rest
            if (trap_req_i.exc_code == ILLEGAL_INSTRUCTION) begin
                regs.mtval <= trap_req_i.instruction;
            end
            else begin
                regs.mtval <= trap_req_i.pc;
            end
        end
        else if (trap_req_i.interrupt_ack) begin
            regs.mcause <= {1'b1, 26'b0, irq_code_i};   // Interrupt flag in bit 31
            regs.mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= privilege;
            regs.mstatus[MSTATUS_MPIE] <= regs.mstatus[MSTATUS_MIE];
            regs.mstatus[MSTATUS_MIE]  <= 1'b0;
            privilege <= PRIV_MACHINE;

            // A taken jump in flight becomes the resume point
            if (trap_req_i.jump) begin
                regs.mepc <= trap_req_i.jump_target;
            end
            else begin
                regs.mepc <= trap_req_i.pc;
            end
        end
        else if (sw_write) begin
            case (csr_access_i.addr)
                MSTATUS:  regs.mstatus  <= wdata_i;
                MISA:     regs.misa     <= wdata_i;
                MIE:      regs.mie      <= wdata_i;
                MTVEC:    regs.mtvec    <= wdata_i;
                MSCRATCH: regs.mscratch <= wdata_i;
                MEPC:     regs.mepc     <= wdata_i;
                MCAUSE:   regs.mcause   <= wdata_i;
                MTVAL:    regs.mtval    <= wdata_i;
                default:  ;                             // Counters or read-only
            endcase
        end
    end

    assign state_o     = regs;
    assign privilege_o = privilege;

endmodule

//--- hdl/csr_write_data.sv
// CSR write data path
// Applies write, set or clear against the current value under a per-CSR mask
`timescale 1ns/1ps

module csr_write_data (
    input  csr_pkg::csr_access_t           csr_access_i,
    input  logic [csr_pkg::XLEN-1:0]       current_val_i,
    output logic [csr_pkg::XLEN-1:0]       wdata_o
);

    import csr_pkg::*;

    logic [XLEN-1:0] wmask;
    logic [XLEN-1:0] combined;

    always_comb begin
        case (csr_access_i.addr)
            MSTATUS:   wmask = 32'h007E19AA;
            MISA:      wmask = 32'h3C000000;   // Only the MXL-adjacent bits
            MIE:       wmask = 32'h00000888;   // MSIE, MTIE, MEIE
            MTVEC:     wmask = 32'hFFFFFFFC;
            MEPC:      wmask = 32'hFFFFFFFC;
            MSCRATCH, MCAUSE, MTVAL,
            MCYCLE, MCYCLEH, MINSTRET, MINSTRETH: begin
                wmask = '1;
            end
            default:   wmask = '0;             // Read-only or unknown
        endcase
    end

    always_comb begin
        case (csr_access_i.op)
            CSR_WRITE: combined = csr_access_i.data;
            CSR_SET:   combined = current_val_i | csr_access_i.data;
            CSR_CLEAR: combined = current_val_i & ~csr_access_i.data;
            default:   combined = '0;
        endcase
    end

    assign wdata_o = combined & wmask;

endmodule

//--- hdl/csr_pkg.sv
// CSR package for the machine-mode CSR bank
// Addresses, operations, trap codes, privilege levels and shared structs
package csr_pkg;

    localparam int XLEN = 32;

    // mstatus bit positions
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

    typedef enum logic [11:0] {
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15,
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,   // User read-only aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82
    } csr_addr_e;

    // Encoding 2'b00 is not a valid operation
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        LOAD_ACCESS_FAULT              = 5'd5,
        STORE_ADDRESS_MISALIGNED       = 5'd6,
        STORE_ACCESS_FAULT             = 5'd7,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_SMODE               = 5'd9,
        ECALL_FROM_MMODE               = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } priv_e;

    typedef struct packed {
        logic            read_en;
        logic            write_en;
        csr_op_e         op;
        csr_addr_e       addr;
        logic [XLEN-1:0] data;
        logic            kill;       // Instruction squashed in the pipeline
    } csr_access_t;

    typedef struct packed {
        logic            raise_exception;
        logic            machine_return;
        logic            interrupt_ack;
        exc_code_e       exc_code;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
        logic            jump;
        logic [XLEN-1:0] jump_target;
    } trap_req_t;

    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] misa;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } machine_state_t;

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
    } counter_state_t;

endpackage
